// File: Makefile
# Verilator build for the store-gathering buffer

VERILATOR ?= verilator
TOP       ?= coreStoreTb
SEED      ?= 94193
BUILD_DIR ?= build
FILELIST  ?= verilog.f

VFLAGS ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := source/coreStore_settings.svh
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-GrandomSeed=$(SEED) --Mdir $(BUILD_DIR) -o V$(TOP)

# exit status of the simulator is the test result
run: $(BINARY)
	./$(BINARY)

clean:
	rm -rf $(BUILD_DIR)

// File: source/coreStorePkg.sv
`default_nettype none

`include "coreStore_settings.svh"

package coreStorePkg;

    // plain vectors for the widths used across the pipeline
    typedef logic [`WORD_WIDTH-1:0]              word_t;
    typedef logic [$clog2(`BUFFER_WORDS)-1:0]    wordAddr_t;
    typedef logic [`ROW_ADDR_WIDTH-1:0]          rowAddr_t;
    typedef logic [$clog2(`MEMORY_ROWS)-1:0]     rowIndex_t;
    typedef logic [`WORDS_PER_ROW*`WORD_WIDTH-1:0] line_t;

    // one core's store request
    typedef struct packed {
        wordAddr_t addr;
        word_t     data;
    } coreStore_t;

    // a gathered batch, core 0 sits at index 0
    typedef struct packed {
        logic                              valid;
        coreStore_t [`CORE_COUNT-1:0]      stores;
    } storeBatch_t;

    // one line on its way to the data memory
    typedef struct packed {
        logic      valid;
        rowIndex_t row;
        line_t     line;
    } lineWrite_t;

endpackage

`default_nettype wire

// File: source/coreStoreTop.sv
`default_nettype none
`timescale 1ns/100ps

`include "coreStore_settings.svh"

// store-gathering buffer top
// gather -> buffer -> drain -> data memory
module coreStoreTop
(
    input  logic                        clk,
    input  logic                        rst,
    // per-core store ports, core 0 first
    input  coreStorePkg::wordAddr_t     storeAddr [`CORE_COUNT],
    input  coreStorePkg::word_t         storeData [`CORE_COUNT],
    input  logic [`CORE_COUNT-1:0]      memWr,
    // drain request
    input  logic                        writeMem,
    input  coreStorePkg::rowAddr_t      rowAddr,
    // memory inspection
    input  coreStorePkg::rowIndex_t     readRow,
    // drained line and its one-cycle qualifier
    output coreStorePkg::line_t         toDataMem,
    output logic                        lineValid,
    output coreStorePkg::line_t         readData
);

    import coreStorePkg::*;

    coreStore_t  coreStores [`CORE_COUNT];
    storeBatch_t batch;
    word_t       bufferWords [`BUFFER_WORDS];
    lineWrite_t  lineWr;

    // pack the flat core ports into store structs
    for (genvar c = 0; c < `CORE_COUNT; c++)
    begin : g_pack
        assign coreStores[c].addr = storeAddr[c];
        assign coreStores[c].data = storeData[c];
    end

    storeGather u_storeGather
    (
        .clk        (clk),
        .rst        (rst),
        .coreStores (coreStores),
        .memWr      (memWr),
        .batch      (batch)
    );

    wordBuffer u_wordBuffer
    (
        .clk         (clk),
        .rst         (rst),
        .batch       (batch),
        .bufferWords (bufferWords)
    );

    rowDrain u_rowDrain
    (
        .clk         (clk),
        .rst         (rst),
        .writeMem    (writeMem),
        .rowAddr     (rowAddr),
        .bufferWords (bufferWords),
        .lineWr      (lineWr)
    );

    rowMemory u_rowMemory
    (
        .clk      (clk),
        .rst      (rst),
        .lineWr   (lineWr),
        .readRow  (readRow),
        .readData (readData)
    );

    // drained line also leaves the block directly
    assign toDataMem = lineWr.line;
    assign lineValid = lineWr.valid;

endmodule

`default_nettype wire

// File: source/coreStore_settings.svh
`ifndef CORE_STORE_SETTINGS_SVH
`define CORE_STORE_SETTINGS_SVH

// number of cores presenting a store each cycle
`define CORE_COUNT 4
// data word width in bits
`define WORD_WIDTH 16
// gathering buffer depth in words
`define BUFFER_WORDS 16
// words packed into one drained line
`define WORDS_PER_ROW 4
// lines held by the data memory
`define MEMORY_ROWS 4
// width of the drain row address, 8..11 are the valid codes
`define ROW_ADDR_WIDTH 4
`define ROW_SELECT_BASE 8

`endif

// File: source/rowDrain.sv
`default_nettype none
`timescale 1ns/100ps

`include "coreStore_settings.svh"

// drain stage
// turns a row address into a memory row index, builds the 64-bit
// line from four buffer words and registers it as a one-cycle write
module rowDrain
(
    input  logic                        clk,
    input  logic                        rst,
    // drain strobe
    input  logic                        writeMem,
    // row address, only 8..11 select a row
    input  coreStorePkg::rowAddr_t      rowAddr,
    // buffer contents
    input  coreStorePkg::word_t         bufferWords [`BUFFER_WORDS],
    // registered line write towards the memory
    output coreStorePkg::lineWrite_t    lineWr
);

    import coreStorePkg::*;

    logic      rowSelected;
    logic      drainHit;
    rowIndex_t drainRow;
    line_t     drainLine;

    // address decode
    // valid window starts at the base and spans one code per memory row
    assign rowSelected = (rowAddr >= rowAddr_t'(`ROW_SELECT_BASE))
                      && (rowAddr <  rowAddr_t'(`ROW_SELECT_BASE + `MEMORY_ROWS));
    assign drainRow    = rowIndex_t'(rowAddr - rowAddr_t'(`ROW_SELECT_BASE));
    assign drainHit    = writeMem && rowSelected;

    // line assembly
    // lowest word of the row goes into the top 16 bits
    always_comb
    begin
        for (int w = 0; w < `WORDS_PER_ROW; w++)
        begin
            drainLine[(`WORDS_PER_ROW - 1 - w) * `WORD_WIDTH +: `WORD_WIDTH] =
                bufferWords[int'(drainRow) * `WORDS_PER_ROW + w];
        end
    end

    always_ff @(posedge clk)
    begin
        // valid is a single-cycle pulse per accepted drain
        if (rst)
        begin
            lineWr.valid <= 1'b0;
        end
        else
        begin
            lineWr.valid <= drainHit;
        end

        // last line is held while idle
        if (drainHit)
        begin
            lineWr.row  <= drainRow;
            lineWr.line <= drainLine;
        end
    end

endmodule

`default_nettype wire

// File: source/rowMemory.sv
`default_nettype none
`timescale 1ns/100ps

`include "coreStore_settings.svh"

// four-line data memory
// one write port fed by the drain stage, one registered read port
module rowMemory
(
    input  logic                        clk,
    input  logic                        rst,
    // line write from the drain stage
    input  coreStorePkg::lineWrite_t    lineWr,
    // inspection read address
    input  coreStorePkg::rowIndex_t     readRow,
    // registered read data
    output coreStorePkg::line_t         readData
);

    import coreStorePkg::*;

    // line storage
    line_t memLines [`MEMORY_ROWS];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            // memory and read register come up zero
            for (int r = 0; r < `MEMORY_ROWS; r++)
            begin
                memLines[r] <= '0;
            end
            readData <= '0;
        end
        else
        begin
            if (lineWr.valid)
            begin
                memLines[lineWr.row] <= lineWr.line;
            end
            // read before write
            // same-row access in the write cycle returns the old line
            readData <= memLines[readRow];
        end
    end

endmodule

`default_nettype wire

// File: source/storeGather.sv
`default_nettype none
`timescale 1ns/100ps

`include "coreStore_settings.svh"

// gather stage
// samples all four core stores on every edge and flags the batch
// as valid only when every core raised its strobe in that cycle
module storeGather
(
    input  logic                        clk,
    input  logic                        rst,
    // per-core address and data, core 0 first
    input  coreStorePkg::coreStore_t    coreStores [`CORE_COUNT],
    // per-core write strobes
    input  logic [`CORE_COUNT-1:0]      memWr,
    // registered batch for the buffer stage
    output coreStorePkg::storeBatch_t   batch
);

    import coreStorePkg::*;

    // unanimous strobe
    // a single low bit drops the whole batch
    logic allWrite;

    assign allWrite = &memWr;

    always_ff @(posedge clk)
    begin
        // only the flag is cleared, the payload is don't-care while invalid
        if (rst)
        begin
            batch.valid <= 1'b0;
        end
        else
        begin
            batch.valid <= allWrite;
        end

        // payload registered every cycle, whatever the strobes
        for (int c = 0; c < `CORE_COUNT; c++)
        begin
            batch.stores[c] <= coreStores[c];
        end
    end

endmodule

`default_nettype wire

// File: source/wordBuffer.sv
`default_nettype none
`timescale 1ns/100ps

`include "coreStore_settings.svh"

// sixteen-word gathering buffer
// a valid batch lands one edge after the gather stage registered it
// and every word is visible to the drain stage in parallel
module wordBuffer
(
    input  logic                        clk,
    input  logic                        rst,
    // batch from the gather stage
    input  coreStorePkg::storeBatch_t   batch,
    // whole buffer contents, word 0 first
    output coreStorePkg::word_t         bufferWords [`BUFFER_WORDS]
);

    import coreStorePkg::*;

    // storage
    word_t words [`BUFFER_WORDS];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            // buffer starts out all zero
            for (int i = 0; i < `BUFFER_WORDS; i++)
            begin
                words[i] <= '0;
            end
        end
        else if (batch.valid)
        begin
            // cores applied in ascending order
            // on an address collision the later assignment sticks,
            // so the highest-numbered core wins
            for (int c = 0; c < `CORE_COUNT; c++)
            begin
                words[batch.stores[c].addr] <= batch.stores[c].data;
            end
        end
        // words not addressed by any core hold their value
    end

    // expose the storage to the drain stage
    always_comb
    begin
        for (int i = 0; i < `BUFFER_WORDS; i++)
        begin
            bufferWords[i] = words[i];
        end
    end

endmodule

`default_nettype wire

// File: tests/coreStoreTb.sv
`default_nettype none
`timescale 1ns/100ps

`include "coreStore_settings.svh"

module coreStoreTb;

    import coreStorePkg::*;

    parameter int randomSeed = 94193;
    // negedges allowed for a drained line to appear
    localparam int pulseTimeout = 8;
    localparam int addrBits = $bits(wordAddr_t);

    logic                   clk;
    logic                   rst;
    wordAddr_t              storeAddr [`CORE_COUNT];
    word_t                  storeData [`CORE_COUNT];
    logic [`CORE_COUNT-1:0] memWr;
    logic                   writeMem;
    rowAddr_t               rowAddr;
    rowIndex_t              readRow;
    line_t                  toDataMem;
    logic                   lineValid;
    line_t                  readData;

    // reference buffer and memory
    word_t bufModel [`BUFFER_WORDS];
    line_t memModel [`MEMORY_ROWS];

    coreStoreTop u_coreStoreTop
    (
        .clk       (clk),
        .rst       (rst),
        .storeAddr (storeAddr),
        .storeData (storeData),
        .memWr     (memWr),
        .writeMem  (writeMem),
        .rowAddr   (rowAddr),
        .readRow   (readRow),
        .toDataMem (toDataMem),
        .lineValid (lineValid),
        .readData  (readData)
    );

    // 10 ns clock
    always #5 clk = ~clk;

    task automatic stopRun(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic failValue(input string testName, input logic [63:0] expected,
                             input logic [63:0] actual);
        stopRun($sformatf("ERROR %s expected %h actual %h", testName, expected, actual));
    endtask

    // each accepted drain gives a single-cycle pulse
    pulseWidth: assert property (@(posedge clk) disable iff (rst) lineValid |=> !lineValid)
        else failValue("lineValidPulse", 64'd0, 64'(lineValid));
    // nothing leaves the drain stage while reset is held
    resetQuiet: assert property (@(posedge clk) rst |=> !lineValid)
        else failValue("resetLineValid", 64'd0, 64'(lineValid));

    // row r holds words 4r..4r+3, lowest word in the top bits
    function automatic line_t expectedLine(input rowIndex_t row);
        return {bufModel[{row, 2'd0}], bufModel[{row, 2'd1}],
                bufModel[{row, 2'd2}], bufModel[{row, 2'd3}]};
    endfunction

    // one batch, core c in field c of the packed arguments
    task automatic applyStore(input logic [addrBits*`CORE_COUNT-1:0] addrs,
                              input logic [`WORD_WIDTH*`CORE_COUNT-1:0] datas,
                              input logic [`CORE_COUNT-1:0] strobes);
        @(posedge clk);
        for (int c = 0; c < `CORE_COUNT; c++)
        begin
            storeAddr[c] <= addrs[c*addrBits +: addrBits];
            storeData[c] <= datas[c*`WORD_WIDTH +: `WORD_WIDTH];
        end
        memWr <= strobes;
        @(posedge clk);
        memWr <= '0;
        // unanimous strobe only
        // later cores overwrite earlier ones
        if (strobes == '1)
        begin
            for (int c = 0; c < `CORE_COUNT; c++)
            begin
                bufModel[addrs[c*addrBits +: addrBits]] = datas[c*`WORD_WIDTH +: `WORD_WIDTH];
            end
        end
    endtask

    task automatic drainRow(input rowAddr_t addr, input string testName);
        int        waited;
        logic      hit;
        rowIndex_t row;
        line_t     expLine;
        // upper two bits 10 select a row
        hit = (addr[3:2] == 2'b10);
        row = addr[1:0];
        expLine = expectedLine(row);
        @(posedge clk);
        writeMem <= 1'b1;
        rowAddr  <= addr;
        @(posedge clk);
        writeMem <= 1'b0;
        if (hit)
        begin
            waited = 0;
            @(negedge clk);
            while (!lineValid && waited < pulseTimeout)
            begin
                @(negedge clk);
                waited++;
            end
            if (!lineValid)
            begin
                stopRun($sformatf("timeout waiting for lineValid in %s", testName));
            end
            else
            begin
                lineLatency: assert (waited == 0)
                    else failValue({testName, "Latency"}, 64'd0, 64'(waited));
                lineData: assert (toDataMem == expLine)
                    else failValue(testName, expLine, toDataMem);
                memModel[row] = expLine;
            end
        end
        else
        begin
            // an invalid row address must stay silent
            for (int i = 0; i < pulseTimeout; i++)
            begin
                @(negedge clk);
                noPulse: assert (!lineValid)
                    else failValue(testName, 64'd0, 64'(lineValid));
            end
        end
    endtask

    task automatic readCheck(input rowIndex_t row, input string testName);
        @(posedge clk);
        readRow <= row;
        @(posedge clk);
        @(negedge clk);
        readMatch: assert (readData == memModel[row])
            else failValue(testName, memModel[row], readData);
    endtask

    task automatic checkAllRows(input string testName);
        for (int r = 0; r < `MEMORY_ROWS; r++)
        begin
            readCheck(rowIndex_t'(r), testName);
        end
    endtask

    initial
    begin
        logic [addrBits*`CORE_COUNT-1:0]    addrs;
        logic [`WORD_WIDTH*`CORE_COUNT-1:0] datas;
        logic [`CORE_COUNT-1:0]             strobes;
        void'($urandom(randomSeed));
        clk      = 1'b0;
        rst      = 1'b1;
        memWr    = '0;
        // a valid drain request held through reset must not pulse
        writeMem = 1'b1;
        rowAddr  = 4'd8;
        readRow  = '0;
        for (int c = 0; c < `CORE_COUNT; c++)
        begin
            storeAddr[c] = '0;
            storeData[c] = '0;
        end
        for (int i = 0; i < `BUFFER_WORDS; i++)
        begin
            bufModel[i] = '0;
        end
        for (int r = 0; r < `MEMORY_ROWS; r++)
        begin
            memModel[r] = '0;
        end
        repeat (10) @(posedge clk);
        rst      <= 1'b0;
        writeMem <= 1'b0;
        @(negedge clk);
        resetValid: assert (!lineValid) else failValue("resetValid", 64'd0, 64'(lineValid));
        checkAllRows("resetRead");
        drainRow(4'd8, "resetDrain");

        // four batches with distinct addresses cover every word
        for (int b = 0; b < 4; b++)
        begin
            for (int c = 0; c < `CORE_COUNT; c++)
            begin
                addrs[c*addrBits +: addrBits] = wordAddr_t'(b * `CORE_COUNT + c);
                datas[c*`WORD_WIDTH +: `WORD_WIDTH] = word_t'($urandom);
            end
            applyStore(addrs, datas, '1);
        end
        for (int a = 8; a < 12; a++)
        begin
            drainRow(rowAddr_t'(a), "fillDrain");
        end
        checkAllRows("fillRead");

        // any low strobe drops the batch
        addrs = 16'h3210;
        datas = 64'hDEAD_BEEF_CAFE_F00D;
        applyStore(addrs, datas, 4'hE);
        applyStore(addrs, datas, 4'h7);
        applyStore(addrs, datas, 4'h0);
        applyStore(addrs, datas, 4'hB);
        drainRow(4'd8, "partialDrain");
        readCheck(2'd0, "partialRead");

        // all cores on word 5 then pairs on words 9 and 10
        applyStore(16'h5555, 64'h4444_3333_2222_1111, '1);
        applyStore(16'h9A9A, 64'h8888_7777_6666_5555, '1);
        drainRow(4'd9, "collisionDrain");
        drainRow(4'd10, "collisionDrain");
        checkAllRows("collisionRead");

        // buffer row 0 now differs from memory row 0
        applyStore(16'h3210, 64'h0123_4567_89AB_CDEF, '1);
        drainRow(4'd0, "invalidRow0");
        drainRow(4'd7, "invalidRow7");
        drainRow(4'd12, "invalidRow12");
        drainRow(4'd15, "invalidRow15");
        checkAllRows("invalidRead");

        for (int n = 0; n < 40; n++)
        begin
            for (int c = 0; c < `CORE_COUNT; c++)
            begin
                addrs[c*addrBits +: addrBits] = wordAddr_t'($urandom);
                datas[c*`WORD_WIDTH +: `WORD_WIDTH] = word_t'($urandom);
            end
            // force a collision now and then
            if ($urandom_range(3) == 0)
            begin
                addrs[3*addrBits +: addrBits] = addrs[0 +: addrBits];
            end
            strobes = ($urandom_range(3) != 0) ? '1 : `CORE_COUNT'($urandom);
            applyStore(addrs, datas, strobes);
            if ($urandom_range(4) == 0)
            begin
                drainRow(rowAddr_t'($urandom), "randomAnyDrain");
            end
            else
            begin
                drainRow(rowAddr_t'(`ROW_SELECT_BASE + $urandom_range(3)), "randomDrain");
            end
            readCheck(rowIndex_t'($urandom), "randomRead");
        end
        checkAllRows("finalRead");

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+source
source/coreStorePkg.sv
source/storeGather.sv
source/wordBuffer.sv
source/rowDrain.sv
source/rowMemory.sv
source/coreStoreTop.sv
tests/coreStoreTb.sv
